/* verilog/core_pkg.sv */
// Shared widths, opcode and debug command encodings, and instruction field positions
// for the core pipeline. Every stage refers to these by scoped name.
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [15:0] imm_t;

	localparam int NUM_GR = 32;

	// Byte step between two instructions
	localparam int INST_BYTES = 4;

	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SHL  = 6'h06,
		OP_SHR  = 6'h07,
		OP_ADDI = 6'h08,
		OP_LUI  = 6'h09,
		OP_BR   = 6'h0a
	} op_t;

	// Field positions with the immediate in the low half
	localparam int OP_MSB   = 31;
	localparam int DEST_LSB = 21;
	localparam int SRC0_LSB = 16;
	localparam int SRC1_LSB = 11;

	typedef enum logic [3:0] {
		DBG_NOP     = 4'h0,
		DBG_READ_GR = 4'h1
	} debug_cmd_t;

endpackage

`default_nettype wire

/* verilog/fetch.sv */
// Instruction fetch. Issues in-order requests to instruction memory while the queue has
// room, tags returned words with their PC and drops words that a branch made stale.
`timescale 1ns/1ps
`default_nettype none

module fetch #(
	parameter int INST_QUEUE_DEPTH = 4,
	parameter core_pkg::addr_t RESET_PC = '0,
	localparam int CNT_W = $clog2(INST_QUEUE_DEPTH + 1)
) (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic flush,
	input wire core_pkg::addr_t flush_pc,
	output logic inst_fetch_req,
	input wire logic inst_fetch_ready,
	output core_pkg::addr_t inst_fetch_addr,
	input wire logic inst_valid,
	input wire core_pkg::word_t inst_data,
	input wire logic [CNT_W-1:0] queue_count,
	output logic fetch_valid,
	output core_pkg::word_t fetch_inst,
	output core_pkg::addr_t fetch_pc
);
	core_pkg::addr_t pc;
	core_pkg::addr_t resp_pc;
	logic [CNT_W-1:0] outstanding;
	logic [CNT_W-1:0] outstanding_next;
	logic [CNT_W-1:0] discard;
	logic [CNT_W:0] in_flight;
	logic accept;
	logic hold;
	logic credit;

	assign accept = inst_fetch_req && inst_fetch_ready;
	assign hold = inst_fetch_req && !inst_fetch_ready;
	assign outstanding_next = outstanding + CNT_W'(accept) - CNT_W'(inst_valid);

	// Queue slots already spoken for by the open request, owed responses and queued words
	assign in_flight = (CNT_W + 1)'(outstanding) + (CNT_W + 1)'(queue_count)
		+ (CNT_W + 1)'(inst_fetch_req);
	assign credit = in_flight < (CNT_W + 1)'(INST_QUEUE_DEPTH);

	// A word arriving with the flush is stale as well
	assign fetch_valid = inst_valid && (discard == '0) && !flush;
	assign fetch_inst = inst_data;
	assign fetch_pc = resp_pc;

	// Request side keeps a waiting request and its address even across a flush
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			inst_fetch_req <= 1'b0;
			inst_fetch_addr <= RESET_PC;
			pc <= RESET_PC;
			outstanding <= '0;
		end else begin
			outstanding <= outstanding_next;
			if (!hold) begin
				inst_fetch_req <= !flush && credit;
				if (!flush && credit) begin
					inst_fetch_addr <= pc;
					pc <= pc + core_pkg::addr_t'(core_pkg::INST_BYTES);
				end
			end
			if (flush)
				pc <= flush_pc;
		end
	end

	// Response side
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			resp_pc <= RESET_PC;
			discard <= '0;
		end else if (flush) begin
			resp_pc <= flush_pc;
			discard <= outstanding_next + CNT_W'(hold);
		end else begin
			if (fetch_valid)
				resp_pc <= resp_pc + core_pkg::addr_t'(core_pkg::INST_BYTES);
			if (inst_valid && discard != '0)
				discard <= discard - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/inst_queue.sv */
// Instruction queue between fetch and decode. Circular FIFO of words with their PCs,
// emptied by a branch flush.
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
	parameter int INST_QUEUE_DEPTH = 4,
	localparam int CNT_W = $clog2(INST_QUEUE_DEPTH + 1),
	localparam int PTR_W = (INST_QUEUE_DEPTH > 1) ? $clog2(INST_QUEUE_DEPTH) : 1
) (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic flush,
	input wire logic fetch_valid,
	input wire core_pkg::word_t fetch_inst,
	input wire core_pkg::addr_t fetch_pc,
	output logic [CNT_W-1:0] queue_count,
	output logic q_valid,
	input wire logic q_ready,
	output core_pkg::word_t q_inst,
	output core_pkg::addr_t q_pc
);
	core_pkg::word_t inst_mem [INST_QUEUE_DEPTH];
	core_pkg::addr_t pc_mem [INST_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(INST_QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign q_valid = queue_count != '0;
	assign q_inst = inst_mem[rd_ptr];
	assign q_pc = pc_mem[rd_ptr];
	assign pop = q_valid && q_ready;

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			inst_mem[wr_ptr] <= fetch_inst;
			pc_mem[wr_ptr] <= fetch_pc;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			queue_count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			queue_count <= '0;
		end else begin
			// Fetch credit keeps a push from landing on a full queue
			if (fetch_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			queue_count <= queue_count + CNT_W'(fetch_valid) - CNT_W'(pop);
		end
	end

endmodule

`default_nettype wire

/* verilog/decoder.sv */
// Decode stage. Registers one instruction word split into opcode, register indexes,
// immediate and PC; unknown opcodes become NOP.
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic flush,
	input wire logic q_valid,
	output logic q_ready,
	input wire core_pkg::word_t q_inst,
	input wire core_pkg::addr_t q_pc,
	output logic dec_valid,
	input wire logic dec_ready,
	output core_pkg::op_t dec_op,
	output core_pkg::reg_idx_t dec_dest,
	output core_pkg::reg_idx_t dec_src0,
	output core_pkg::reg_idx_t dec_src1,
	output core_pkg::imm_t dec_imm,
	output core_pkg::addr_t dec_pc
);
	logic load;

	function automatic core_pkg::op_t decode_op(input logic [5:0] code);
		case (code)
			core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_OR,
			core_pkg::OP_XOR, core_pkg::OP_SHL, core_pkg::OP_SHR, core_pkg::OP_ADDI,
			core_pkg::OP_LUI, core_pkg::OP_BR:
				return core_pkg::op_t'(code);
			default:
				return core_pkg::OP_NOP;
		endcase
	endfunction

	// Stage is free when empty or draining this cycle
	assign q_ready = !dec_valid || dec_ready;
	assign load = q_valid && q_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			dec_valid <= 1'b0;
		else if (flush)
			dec_valid <= 1'b0;
		else if (q_ready)
			dec_valid <= q_valid;
	end

	always_ff @(posedge clock) begin
		if (load) begin
			dec_op <= decode_op(q_inst[core_pkg::OP_MSB -: $bits(core_pkg::op_t)]);
			dec_dest <= q_inst[core_pkg::DEST_LSB +: $bits(core_pkg::reg_idx_t)];
			dec_src0 <= q_inst[core_pkg::SRC0_LSB +: $bits(core_pkg::reg_idx_t)];
			dec_src1 <= q_inst[core_pkg::SRC1_LSB +: $bits(core_pkg::reg_idx_t)];
			dec_imm <= q_inst[$bits(core_pkg::imm_t)-1:0];
			dec_pc <= q_pc;
		end
	end

endmodule

`default_nettype wire

/* verilog/dispatch.sv */
// Dispatch stage with the general register file and a busy bit per register.
// Holds back an instruction until its sources are written, then reads its operands.
`timescale 1ns/1ps
`default_nettype none

module dispatch (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic flush,
	input wire logic dec_valid,
	output logic dec_ready,
	input wire core_pkg::op_t dec_op,
	input wire core_pkg::reg_idx_t dec_dest,
	input wire core_pkg::reg_idx_t dec_src0,
	input wire core_pkg::reg_idx_t dec_src1,
	input wire core_pkg::imm_t dec_imm,
	input wire core_pkg::addr_t dec_pc,
	output logic iss_valid,
	input wire logic iss_ready,
	output core_pkg::op_t iss_op,
	output core_pkg::reg_idx_t iss_dest,
	output core_pkg::word_t iss_a,
	output core_pkg::word_t iss_b,
	output core_pkg::imm_t iss_imm,
	output core_pkg::addr_t iss_pc,
	input wire logic wb_valid,
	input wire core_pkg::reg_idx_t wb_dest,
	input wire core_pkg::word_t wb_data,
	input wire core_pkg::reg_idx_t dbg_rd_idx,
	output core_pkg::word_t dbg_rd_data
);
	core_pkg::word_t regs [core_pkg::NUM_GR];
	logic [core_pkg::NUM_GR-1:0] busy;
	logic use_src0;
	logic use_src1;
	logic held_writes;
	logic hazard;
	logic accept;

	function automatic logic writes_dest(input core_pkg::op_t op);
		return !(op == core_pkg::OP_NOP || op == core_pkg::OP_BR);
	endfunction

	// Which source fields the incoming opcode reads
	always_comb begin
		use_src0 = 1'b0;
		use_src1 = 1'b0;
		case (dec_op)
			core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_OR,
			core_pkg::OP_XOR, core_pkg::OP_SHL, core_pkg::OP_SHR: begin
				use_src0 = 1'b1;
				use_src1 = 1'b1;
			end
			core_pkg::OP_ADDI: use_src0 = 1'b1;
			default: ;
		endcase
	end

	// The held instruction has not marked its destination busy yet
	assign held_writes = iss_valid && writes_dest(iss_op);
	assign hazard = (use_src0 && (busy[dec_src0] || (held_writes && iss_dest == dec_src0)))
		|| (use_src1 && (busy[dec_src1] || (held_writes && iss_dest == dec_src1)));

	assign dec_ready = !flush && (!iss_valid || iss_ready) && !hazard;
	assign accept = dec_valid && dec_ready;
	assign dbg_rd_data = regs[dbg_rd_idx];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < core_pkg::NUM_GR; i++)
				regs[i] <= '0;
			busy <= '0;
		end else begin
			if (wb_valid) begin
				regs[wb_dest] <= wb_data;
				busy[wb_dest] <= 1'b0;
			end
			// Set after clear so a new writer of the same register wins
			if (iss_valid && iss_ready && writes_dest(iss_op))
				busy[iss_dest] <= 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			iss_valid <= 1'b0;
		else if (flush)
			iss_valid <= 1'b0;
		else if (!iss_valid || iss_ready)
			iss_valid <= accept;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			iss_op <= dec_op;
			iss_dest <= dec_dest;
			iss_a <= regs[dec_src0];
			iss_b <= regs[dec_src1];
			iss_imm <= dec_imm;
			iss_pc <= dec_pc;
		end
	end

endmodule

`default_nettype wire

/* verilog/execute.sv */
// Execute stage. One-cycle ALU into the writeback register; a branch here
// redirects fetch and clears the front of the pipeline for one cycle.
`timescale 1ns/1ps
`default_nettype none

module execute (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic iss_valid,
	output logic iss_ready,
	input wire core_pkg::op_t iss_op,
	input wire core_pkg::reg_idx_t iss_dest,
	input wire core_pkg::word_t iss_a,
	input wire core_pkg::word_t iss_b,
	input wire core_pkg::imm_t iss_imm,
	input wire core_pkg::addr_t iss_pc,
	output logic wb_valid,
	output core_pkg::reg_idx_t wb_dest,
	output core_pkg::word_t wb_data,
	output logic flush,
	output core_pkg::addr_t flush_pc
);
	core_pkg::word_t imm_sext;
	core_pkg::word_t result;
	core_pkg::addr_t target;
	logic take;

	assign iss_ready = !flush;
	assign take = iss_valid && iss_ready;
	assign imm_sext = core_pkg::word_t'($signed(iss_imm));
	assign target = iss_pc + core_pkg::addr_t'(imm_sext * core_pkg::INST_BYTES);

	always_comb begin
		case (iss_op)
			core_pkg::OP_ADD:  result = iss_a + iss_b;
			core_pkg::OP_SUB:  result = iss_a - iss_b;
			core_pkg::OP_AND:  result = iss_a & iss_b;
			core_pkg::OP_OR:   result = iss_a | iss_b;
			core_pkg::OP_XOR:  result = iss_a ^ iss_b;
			core_pkg::OP_SHL:  result = iss_a << iss_b[4:0];
			core_pkg::OP_SHR:  result = iss_a >> iss_b[4:0];
			core_pkg::OP_ADDI: result = iss_a + imm_sext;
			core_pkg::OP_LUI:  result = {iss_imm, 16'h0000};
			default:           result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			flush <= 1'b0;
		end else begin
			wb_valid <= take && iss_op != core_pkg::OP_NOP && iss_op != core_pkg::OP_BR;
			flush <= take && iss_op == core_pkg::OP_BR;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			wb_dest <= iss_dest;
			wb_data <= result;
			flush_pc <= target;
		end
	end

endmodule

`default_nettype wire

/* verilog/core_debug.sv */
// Debug command decoder. Answers each command one cycle later with register data,
// zero for a NOP, or an error for a bad target or command.
`timescale 1ns/1ps
`default_nettype none

module core_debug (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic dbg_cmd_valid,
	input wire core_pkg::debug_cmd_t dbg_cmd,
	input wire logic [7:0] dbg_target,
	output core_pkg::reg_idx_t dbg_rd_idx,
	input wire core_pkg::word_t dbg_rd_data,
	output logic dbg_resp_valid,
	output logic dbg_resp_error,
	output core_pkg::word_t dbg_resp_data
);
	assign dbg_rd_idx = dbg_target[$bits(core_pkg::reg_idx_t)-1:0];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			dbg_resp_valid <= 1'b0;
			dbg_resp_error <= 1'b0;
			dbg_resp_data <= '0;
		end else begin
			dbg_resp_valid <= dbg_cmd_valid;
			dbg_resp_error <= 1'b0;
			dbg_resp_data <= '0;
			if (dbg_cmd_valid) begin
				case (dbg_cmd)
					core_pkg::DBG_READ_GR: begin
						if (dbg_target < core_pkg::NUM_GR)
							dbg_resp_data <= dbg_rd_data;
						else
							dbg_resp_error <= 1'b1;
					end
					core_pkg::DBG_NOP: ;
					default: dbg_resp_error <= 1'b1;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/core_pipeline.sv */
// Top level of the in-order core: fetch, instruction queue, decoder, dispatch and execute,
// plus the debug command port for reading general registers.
`timescale 1ns/1ps
`default_nettype none

module core_pipeline #(
	parameter int INST_QUEUE_DEPTH = 4,
	parameter core_pkg::addr_t RESET_PC = '0,
	localparam int CNT_W = $clog2(INST_QUEUE_DEPTH + 1)
) (
	input wire logic clock,
	input wire logic arst_n,
	// Instruction memory
	output logic inst_fetch_req,
	input wire logic inst_fetch_ready,
	output core_pkg::addr_t inst_fetch_addr,
	input wire logic inst_valid,
	input wire core_pkg::word_t inst_data,
	// Debug commands
	input wire logic dbg_cmd_valid,
	input wire core_pkg::debug_cmd_t dbg_cmd,
	input wire logic [7:0] dbg_target,
	output logic dbg_resp_valid,
	output logic dbg_resp_error,
	output core_pkg::word_t dbg_resp_data
);
	// Fetch to queue
	logic fetch_valid;
	core_pkg::word_t fetch_inst;
	core_pkg::addr_t fetch_pc;
	logic [CNT_W-1:0] queue_count;

	// Queue to decoder
	logic q_valid;
	logic q_ready;
	core_pkg::word_t q_inst;
	core_pkg::addr_t q_pc;

	// Decoder to dispatch
	logic dec_valid;
	logic dec_ready;
	core_pkg::op_t dec_op;
	core_pkg::reg_idx_t dec_dest;
	core_pkg::reg_idx_t dec_src0;
	core_pkg::reg_idx_t dec_src1;
	core_pkg::imm_t dec_imm;
	core_pkg::addr_t dec_pc;

	// Dispatch to execute
	logic iss_valid;
	logic iss_ready;
	core_pkg::op_t iss_op;
	core_pkg::reg_idx_t iss_dest;
	core_pkg::word_t iss_a;
	core_pkg::word_t iss_b;
	core_pkg::imm_t iss_imm;
	core_pkg::addr_t iss_pc;

	// Writeback and branch redirect
	logic wb_valid;
	core_pkg::reg_idx_t wb_dest;
	core_pkg::word_t wb_data;
	logic flush;
	core_pkg::addr_t flush_pc;

	// Debug register read
	core_pkg::reg_idx_t dbg_rd_idx;
	core_pkg::word_t dbg_rd_data;

	fetch #(
		.INST_QUEUE_DEPTH(INST_QUEUE_DEPTH),
		.RESET_PC(RESET_PC)
	) u_fetch (.*);

	inst_queue #(
		.INST_QUEUE_DEPTH(INST_QUEUE_DEPTH)
	) u_inst_queue (.*);

	decoder u_decoder (.*);

	dispatch u_dispatch (.*);

	execute u_execute (.*);

	core_debug u_core_debug (.*);

endmodule

`default_nettype wire

/* dv/core_pipeline_tb.sv */
// Testbench for the core pipeline. Runs the golden program from a random-latency
// instruction memory, then checks registers and error responses over the debug port.
`timescale 1ns/1ps
`default_nettype none

module core_pipeline_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int HALT_LOOPS = 8;
	localparam int CYCLES_PER_WORD = 2000;

	logic clock = 1'b0;
	logic arst_n;
	logic inst_fetch_req;
	logic inst_fetch_ready = 1'b0;
	core_pkg::addr_t inst_fetch_addr;
	logic inst_valid = 1'b0;
	core_pkg::word_t inst_data = '0;
	logic dbg_cmd_valid;
	core_pkg::debug_cmd_t dbg_cmd;
	logic [7:0] dbg_target;
	logic dbg_resp_valid;
	logic dbg_resp_error;
	core_pkg::word_t dbg_resp_data;

	// Golden program and expected results
	core_pkg::word_t prog [core_pkg::addr_t];
	core_pkg::addr_t halt_addr = '0;
	core_pkg::addr_t max_addr = '0;
	int num_words = 0;
	logic golden_loaded = 1'b0;
	logic [7:0] reg_idx_q [$];
	core_pkg::word_t reg_val_q [$];
	logic [3:0] err_cmd_q [$];
	logic [7:0] err_tgt_q [$];

	// Instruction memory model
	core_pkg::addr_t mem_addr_q [$];
	int unsigned mem_due_q [$];
	int unsigned cycle_count = 0;
	logic accept_seen = 1'b0;
	core_pkg::addr_t accept_addr = '0;
	core_pkg::addr_t resp_addr;

	logic req_waiting = 1'b0;
	core_pkg::addr_t waiting_addr = '0;
	logic resp_expected = 1'b0;
	int halt_count = 0;
	int check_count = 0;
	int mismatch_count = 0;
	int other_errors = 0;

	core_pipeline #(
		.INST_QUEUE_DEPTH(QUEUE_DEPTH),
		.RESET_PC('0)
	) UUT (
		.clock(clock),
		.arst_n(arst_n),
		.inst_fetch_req(inst_fetch_req),
		.inst_fetch_ready(inst_fetch_ready),
		.inst_fetch_addr(inst_fetch_addr),
		.inst_valid(inst_valid),
		.inst_data(inst_data),
		.dbg_cmd_valid(dbg_cmd_valid),
		.dbg_cmd(dbg_cmd),
		.dbg_target(dbg_target),
		.dbg_resp_valid(dbg_resp_valid),
		.dbg_resp_error(dbg_resp_error),
		.dbg_resp_data(dbg_resp_data)
	);

	always #4 clock = ~clock;

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic load_golden(output logic ok);
		int fd;
		int n;
		int ch;
		logic [7:0] tag;
		logic [31:0] a;
		logic [31:0] b;
		ok = 1'b0;
		fd = $fopen("dv/core_pipeline_golden.txt", "r");
		if (fd == 0)
			return;
		ok = 1'b1;
		while (!$feof(fd)) begin
			n = $fscanf(fd, " %c", tag);
			if (n == 1) begin
				case (tag)
					"#": begin
						ch = $fgetc(fd);
						while (ch != 10 && ch != -1)
							ch = $fgetc(fd);
					end
					"I": begin
						n = $fscanf(fd, "%h %h", a, b);
						prog[a] = b;
						num_words++;
					end
					"H": n = $fscanf(fd, "%h", halt_addr);
					"R": begin
						n = $fscanf(fd, "%h %h", a, b);
						reg_idx_q.push_back(a[7:0]);
						reg_val_q.push_back(b);
					end
					"E": begin
						n = $fscanf(fd, "%h %h", a, b);
						err_cmd_q.push_back(a[3:0]);
						err_tgt_q.push_back(b[7:0]);
					end
					default: begin
						ok = 1'b0;
						$display("golden file has a line with unknown tag %c", tag);
					end
				endcase
			end
		end
		$fclose(fd);
		if (num_words == 0)
			ok = 1'b0;
	endtask

	// One command cycle with the response sampled mid-cycle after the next edge
	task automatic send_debug(input logic [3:0] cmd, input logic [7:0] target);
		@(posedge clock);
		#1;
		dbg_cmd_valid = 1'b1;
		dbg_cmd = core_pkg::debug_cmd_t'(cmd);
		dbg_target = target;
		@(posedge clock);
		#1;
		dbg_cmd_valid = 1'b0;
		dbg_cmd = core_pkg::DBG_NOP;
		dbg_target = '0;
		@(negedge clock);
	endtask

	task automatic read_register(input logic [7:0] idx, input core_pkg::word_t expected);
		send_debug(core_pkg::DBG_READ_GR, idx);
		check_value(32'(dbg_resp_valid), 32'd1, $sformatf("response valid for r%0d", idx));
		check_value(32'(dbg_resp_error), 32'd0, $sformatf("error flag for r%0d", idx));
		check_value(dbg_resp_data, expected, $sformatf("value of r%0d", idx));
	endtask

	task automatic expect_error(input logic [3:0] cmd, input logic [7:0] target);
		send_debug(cmd, target);
		check_value(32'(dbg_resp_valid), 32'd1,
			$sformatf("response valid for command %h target %h", cmd, target));
		check_value(32'(dbg_resp_error), 32'd1,
			$sformatf("error flag for command %h target %h", cmd, target));
		check_value(dbg_resp_data, 32'd0,
			$sformatf("data for command %h target %h", cmd, target));
	endtask

	// Memory side returns words in order 1 to 4 cycles after acceptance
	always @(posedge clock) begin
		#1;
		cycle_count++;
		if (accept_seen) begin
			mem_addr_q.push_back(accept_addr);
			mem_due_q.push_back(cycle_count + $urandom_range(3, 0));
		end
		inst_valid = 1'b0;
		inst_data = '0;
		if (mem_due_q.size() != 0 && mem_due_q[0] <= cycle_count) begin
			resp_addr = mem_addr_q.pop_front();
			mem_due_q.delete(0);
			inst_valid = 1'b1;
			inst_data = prog.exists(resp_addr) ? prog[resp_addr] : '0;
		end
		inst_fetch_ready = ($urandom_range(3, 0) != 0);
	end

	// Mid-cycle monitor of the fetch port and the debug response timing
	always @(negedge clock) begin
		accept_seen = 1'b0;
		if (arst_n) begin
			if (req_waiting) begin
				if (!inst_fetch_req) begin
					other_errors++;
					$display("fetch request withdrawn before acceptance at %0t", $time);
				end
				check_value(inst_fetch_addr, waiting_addr, "fetch address while waiting");
			end
			if (inst_fetch_req
				&& (inst_fetch_addr > max_addr || inst_fetch_addr[1:0] != 2'b00)) begin
				other_errors++;
				$display("fetch requested address %h outside the program at %0t",
					inst_fetch_addr, $time);
			end
			if (inst_fetch_req && inst_fetch_ready) begin
				accept_seen = 1'b1;
				accept_addr = inst_fetch_addr;
				if (inst_fetch_addr == halt_addr)
					halt_count++;
			end
			if (dbg_resp_valid || resp_expected)
				check_value(32'(dbg_resp_valid), 32'(resp_expected), "debug response valid");
			req_waiting = inst_fetch_req && !inst_fetch_ready;
			waiting_addr = inst_fetch_addr;
			resp_expected = dbg_cmd_valid;
		end
	end

	initial begin
		wait (golden_loaded);
		repeat (CYCLES_PER_WORD * num_words) @(posedge clock);
		$display("timeout after %0d cycles without finishing the tests",
			CYCLES_PER_WORD * num_words);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic ok;
		arst_n = 1'b0;
		dbg_cmd_valid = 1'b0;
		dbg_cmd = core_pkg::DBG_NOP;
		dbg_target = '0;
		void'($urandom(16844));
		load_golden(ok);
		if (!ok) begin
			$display("golden file is missing or malformed");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			// Decode and dispatch registers can hold two words beyond the queue
			max_addr = halt_addr
				+ core_pkg::addr_t'((QUEUE_DEPTH + 2) * core_pkg::INST_BYTES);
			golden_loaded = 1'b1;
			repeat (8) @(posedge clock);
			#1;
			arst_n = 1'b1;
			wait (halt_count >= HALT_LOOPS);
			foreach (reg_idx_q[i])
				read_register(reg_idx_q[i], reg_val_q[i]);
			send_debug(core_pkg::DBG_NOP, 8'h05);
			check_value(32'(dbg_resp_error), 32'd0, "error flag for debug NOP");
			check_value(dbg_resp_data, 32'd0, "data for debug NOP");
			foreach (err_cmd_q[i])
				expect_error(err_cmd_q[i], err_tgt_q[i]);
			repeat (2) @(posedge clock);
			$display("checks %0d, mismatches %0d, other errors %0d",
				check_count, mismatch_count, other_errors);
			if (mismatch_count == 0 && other_errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* build.f */
verilog/core_pkg.sv
verilog/fetch.sv
verilog/inst_queue.sv
verilog/decoder.sv
verilog/dispatch.sv
verilog/execute.sv
verilog/core_debug.sv
verilog/core_pipeline.sv
dv/core_pipeline_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compiles the core pipeline testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module core_pipeline_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vcore_pipeline_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$output"; then
	exit 0
fi
exit 1

/* dv/core_pipeline_golden.txt */
# I addr word is a program word, H addr is the final branch-to-self, all numbers hex
# R idx value is an expected register, E cmd target is a debug command that must fail
I 00000000 20200005
I 00000004 20410003
I 00000008 04611000
I 0000000c 08830800
I 00000010 0ca31000
I 00000014 10c31000
I 00000018 14e31000
I 0000001c 19011000
I 00000020 25208000
I 00000024 1d490800
I 00000028 2160ffff
# Forward branch over the next two words
I 0000002c 28000003
I 00000030 20200077
I 00000034 21800055
I 00000038 058b5800
I 0000003c 00000000
# Unknown opcode with r13 in the destination field
I 00000040 fda00000
I 00000044 28000000
H 00000044
R 00 00000000
R 01 00000005
R 02 00000008
R 03 0000000d
R 04 00000008
R 05 00000008
R 06 0000000d
R 07 00000005
R 08 00000500
R 09 80000000
R 0a 04000000
R 0b ffffffff
R 0c fffffffe
R 0d 00000000
R 1f 00000000
E 1 20
E 1 ff
E 7 00
E f 03
